// File: rtl/exPkg.sv
package exPkg;

	parameter int dataWidthDefault = 32;	// Core data word
	parameter int addrWidth = 10;			// Word address, not byte
	parameter int regIdWidth = 4;			// Destination register id

	// Command sits in the top nibble of both forms
	typedef enum logic [3:0] {
		cmdNop = 4'd0,
		cmdAlu = 4'd1,
		cmdLoad = 4'd2,
		cmdStore = 4'd3
	} opCmd;

	typedef enum logic [2:0] {
		fnAdd = 3'd0,
		fnSub = 3'd1,
		fnAnd = 3'd2,
		fnOr = 3'd3,
		fnXor = 3'd4,
		fnShl = 3'd5			// Shift by low 5 bits of operand B
	} aluFn;

	typedef struct packed {
		opCmd cmd;
		logic [regIdWidth-1:0] rd;
		aluFn fn;
		logic useImm;				// Operand B from imm, not Rt
		logic [3:0] imm;			// Zero-extended
	} aluForm;

	typedef struct packed {
		opCmd cmd;
		logic [regIdWidth-1:0] rd;
		logic [7:0] offset;			// Word offset, zero-extended
	} memForm;

	// One 16-bit micro-op word, read as either form
	typedef union packed {
		aluForm alu;
		memForm mem;
	} uopWord;

	typedef enum logic {
		srcCore = 1'b0,
		srcHost = 1'b1
	} reqSrc;

endpackage

// File: rtl/memBus.sv
interface memBus import exPkg::*; #(
	parameter int dataWidth = dataWidthDefault
) ();

	logic reqValid;
	logic reqWrite;							// High for store
	logic [addrWidth-1:0] reqAddr;
	logic [dataWidth-1:0] reqData;			// Store data only
	logic reqReady;
	logic rspValid;							// One pulse per accepted request
	logic [dataWidth-1:0] rspData;
	logic rspFault;							// Address out of range

	modport requester (
		output reqValid, reqWrite, reqAddr, reqData,
		input reqReady, rspValid, rspData, rspFault
	);

	modport responder (
		input reqValid, reqWrite, reqAddr, reqData,
		output reqReady, rspValid, rspData, rspFault
	);

endinterface

// File: rtl/exIssueStage.sv
module exIssueStage import exPkg::*; #(
	parameter int dataWidth = dataWidthDefault
) (
	input logic clock,
	input logic rstN,
	input logic opValid,
	input uopWord opWord,
	input logic [dataWidth-1:0] regValRs,
	input logic [dataWidth-1:0] regValRt,
	input logic flush,
	input logic stall,
	output logic opReady,
	output logic issValid,
	output logic issIsLoad,
	output logic [regIdWidth-1:0] issRd,
	output logic [dataWidth-1:0] issValue,
	memBus.requester mem
);

	uopWord opQ;
	logic fullQ;
	logic readyQ;						// Opens the input once reset is done
	logic [dataWidth-1:0] rsQ;
	logic [dataWidth-1:0] rtQ;
	logic [dataWidth-1:0] operandB;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] addrSum;
	logic isAlu;
	logic isLoad;
	logic isMem;
	logic live;
	logic advance;

	assign isAlu = opQ.alu.cmd == cmdAlu;
	assign isLoad = opQ.mem.cmd == cmdLoad;
	assign isMem = isLoad || opQ.mem.cmd == cmdStore;
	assign live = fullQ && !flush;		// Flushed op drops out here

	always_comb begin
		operandB = opQ.alu.useImm ? dataWidth'(opQ.alu.imm) : rtQ;
		case (opQ.alu.fn)
			fnAdd: aluResult = rsQ + operandB;
			fnSub: aluResult = rsQ - operandB;
			fnAnd: aluResult = rsQ & operandB;
			fnOr: aluResult = rsQ | operandB;
			fnXor: aluResult = rsQ ^ operandB;
			fnShl: aluResult = rsQ << operandB[4:0];
			default: aluResult = '0;
		endcase
	end

	assign addrSum = rsQ + dataWidth'(opQ.mem.offset);

	// Request is held from registered op until granted
	assign mem.reqValid = live && isMem && !stall;
	assign mem.reqWrite = !isLoad;
	assign mem.reqAddr = addrSum[addrWidth-1:0];
	assign mem.reqData = rtQ;

	// Empty, flushed, or op leaves this edge
	assign advance = !fullQ || flush || (!stall && (!isMem || mem.reqReady));
	assign opReady = readyQ && advance;

	// Stores retire here, only ALU ops and loads go on
	assign issValid = live && !stall && (isAlu || (isLoad && mem.reqReady));
	assign issIsLoad = isLoad;
	assign issRd = opQ.alu.rd;
	assign issValue = aluResult;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			fullQ <= 1'b0;
			readyQ <= 1'b0;
		end else begin
			readyQ <= 1'b1;
			if (advance)
				fullQ <= opValid && opReady;
		end
	end

	always_ff @(posedge clock) begin
		if (opValid && opReady) begin
			opQ <= opWord;
			rsQ <= regValRs;
			rtQ <= regValRt;
		end
	end

	reqStable: assert property (@(posedge clock) disable iff (!rstN)
		mem.reqValid && !mem.reqReady |=>
			$stable(mem.reqWrite) && $stable(mem.reqAddr) && $stable(mem.reqData))
		else $error("Memory request changed while waiting for grant");

endmodule

// File: rtl/exCompleteStage.sv
module exCompleteStage import exPkg::*; #(
	parameter int dataWidth = dataWidthDefault
) (
	input logic clock,
	input logic rstN,
	input logic issValid,
	input logic issIsLoad,
	input logic [regIdWidth-1:0] issRd,
	input logic [dataWidth-1:0] issValue,
	input logic rspValid,
	input logic [dataWidth-1:0] rspData,
	input logic rspFault,
	output logic stall,
	output logic wbValid,
	output logic [regIdWidth-1:0] wbRegId,
	output logic [dataWidth-1:0] wbValue,
	output logic wbFault
);

	logic pendLoadQ;
	logic [regIdWidth-1:0] pendRdQ;
	logic loadDone;
	logic aluIn;

	// Responses with no load pending belong to stores and are dropped
	assign loadDone = pendLoadQ && rspValid;
	assign aluIn = issValid && !issIsLoad;

	assign stall = pendLoadQ;			// Hold issue while load is out

	always_ff @(posedge clock) begin
		if (!rstN) begin
			pendLoadQ <= 1'b0;
			wbValid <= 1'b0;
		end else begin
			pendLoadQ <= (issValid && issIsLoad) || (pendLoadQ && !rspValid);
			wbValid <= loadDone || aluIn;
		end
	end

	always_ff @(posedge clock) begin
		if (issValid && issIsLoad)
			pendRdQ <= issRd;
		if (loadDone) begin
			wbRegId <= pendRdQ;
			wbValue <= rspFault ? '0 : rspData;	// Faulted load gives zero
			wbFault <= rspFault;
		end else if (aluIn) begin
			wbRegId <= issRd;				// ALU result forwarded as is
			wbValue <= issValue;
			wbFault <= 1'b0;
		end
	end

	// Grant and handoff share an edge, the RAM answers one cycle later
	loadAnswered: assert property (@(posedge clock) disable iff (!rstN)
		issValid && issIsLoad |=> rspValid)
		else $error("Load handed over without a response on the next cycle");

endmodule

// File: rtl/hostPort.sv
module hostPort import exPkg::*; #(
	parameter int dataWidth = dataWidthDefault
) (
	input logic clock,
	input logic rstN,
	input logic hostValid,
	input logic hostWrite,
	input logic [addrWidth-1:0] hostAddr,
	input logic [dataWidth-1:0] hostWData,
	output logic hostReady,
	output logic hostRspValid,
	output logic [dataWidth-1:0] hostRData,
	output logic hostFault,
	memBus.requester mem
);

	logic readyQ;
	logic pendQ;						// Request held, waiting for grant
	logic waitQ;						// Granted, waiting for response
	logic writeQ;
	logic [addrWidth-1:0] addrQ;
	logic [dataWidth-1:0] dataQ;

	assign hostReady = readyQ && !pendQ && !waitQ;

	assign mem.reqValid = pendQ;
	assign mem.reqWrite = writeQ;
	assign mem.reqAddr = addrQ;
	assign mem.reqData = dataQ;

	assign hostRspValid = waitQ && mem.rspValid;
	assign hostRData = mem.rspData;
	assign hostFault = mem.rspFault;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			readyQ <= 1'b0;
			pendQ <= 1'b0;
			waitQ <= 1'b0;
		end else begin
			readyQ <= 1'b1;
			if (hostValid && hostReady)
				pendQ <= 1'b1;
			else if (mem.reqReady)
				pendQ <= 1'b0;
			if (pendQ && mem.reqReady)
				waitQ <= 1'b1;
			else if (mem.rspValid)
				waitQ <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (hostValid && hostReady) begin
			writeQ <= hostWrite;
			addrQ <= hostAddr;
			dataQ <= hostWData;
		end
	end

endmodule

// File: rtl/memArbiter.sv
module memArbiter import exPkg::*; (
	input logic clock,
	input logic rstN,
	memBus.responder coreSide,
	memBus.responder hostSide,
	memBus.requester ramSide
);

	reqSrc lastQ;						// Last source granted
	reqSrc rspSrcQ;						// Owner of the response in flight
	logic grantCore;
	logic grantHost;

	// On contention the side not served last wins
	assign grantHost = hostSide.reqValid && (!coreSide.reqValid || lastQ == srcCore);
	assign grantCore = coreSide.reqValid && (!hostSide.reqValid || lastQ == srcHost);

	assign ramSide.reqValid = grantCore || grantHost;
	assign ramSide.reqWrite = grantHost ? hostSide.reqWrite : coreSide.reqWrite;
	assign ramSide.reqAddr = grantHost ? hostSide.reqAddr : coreSide.reqAddr;
	assign ramSide.reqData = grantHost ? hostSide.reqData : coreSide.reqData;

	assign coreSide.reqReady = grantCore && ramSide.reqReady;
	assign hostSide.reqReady = grantHost && ramSide.reqReady;

	assign coreSide.rspValid = ramSide.rspValid && rspSrcQ == srcCore;
	assign hostSide.rspValid = ramSide.rspValid && rspSrcQ == srcHost;
	assign coreSide.rspData = ramSide.rspData;
	assign hostSide.rspData = ramSide.rspData;
	assign coreSide.rspFault = ramSide.rspFault;
	assign hostSide.rspFault = ramSide.rspFault;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			lastQ <= srcHost;
			rspSrcQ <= srcCore;
		end else if (ramSide.reqValid && ramSide.reqReady) begin
			lastQ <= grantHost ? srcHost : srcCore;
			rspSrcQ <= grantHost ? srcHost : srcCore;
		end
	end

	oneGrant: assert property (@(posedge clock) disable iff (!rstN)
		!(coreSide.reqReady && hostSide.reqReady))
		else $error("Both requesters granted in one cycle");

	coreRspRouted: assert property (@(posedge clock) disable iff (!rstN)
		coreSide.reqValid && coreSide.reqReady |=> coreSide.rspValid && !hostSide.rspValid)
		else $error("Core response missing or sent to host");

	hostRspRouted: assert property (@(posedge clock) disable iff (!rstN)
		hostSide.reqValid && hostSide.reqReady |=> hostSide.rspValid && !coreSide.rspValid)
		else $error("Host response missing or sent to core");

endmodule

// File: rtl/scratchRam.sv
module scratchRam #(
	parameter int memDepth = 256,
	parameter int dataWidth = 32
) (
	input logic clock,
	input logic rstN,
	memBus.responder mem
);

	localparam int idxWidth = $clog2(memDepth);

	logic [dataWidth-1:0] ram [memDepth];
	logic [idxWidth-1:0] idx;
	logic inRange;
	logic rspValidQ;
	logic rspFaultQ;
	logic [dataWidth-1:0] rspDataQ;

	assign idx = mem.reqAddr[idxWidth-1:0];
	assign inRange = 32'(mem.reqAddr) < memDepth;

	assign mem.reqReady = 1'b1;		// Never back-pressures
	assign mem.rspValid = rspValidQ;
	assign mem.rspData = rspDataQ;
	assign mem.rspFault = rspFaultQ;

	always_ff @(posedge clock) begin
		if (!rstN)
			rspValidQ <= 1'b0;
		else
			rspValidQ <= mem.reqValid;
	end

	always_ff @(posedge clock) begin
		if (mem.reqValid) begin
			rspFaultQ <= !inRange;
			// Writes and bad addresses return zero
			rspDataQ <= (inRange && !mem.reqWrite) ? ram[idx] : '0;
			if (mem.reqWrite && inRange)
				ram[idx] <= mem.reqData;
		end
	end

endmodule

// File: rtl/exCore.sv
module exCore import exPkg::*; #(
	parameter int memDepth = 256,
	parameter int dataWidth = dataWidthDefault
) (
	input logic clock,
	input logic rstN,
	input logic opValid,
	input uopWord opWord,
	input logic [dataWidth-1:0] regValRs,
	input logic [dataWidth-1:0] regValRt,
	input logic flush,
	input logic hostValid,
	input logic hostWrite,
	input logic [addrWidth-1:0] hostAddr,
	input logic [dataWidth-1:0] hostWData,
	output logic opReady,
	output logic wbValid,
	output logic [regIdWidth-1:0] wbRegId,
	output logic [dataWidth-1:0] wbValue,
	output logic wbFault,
	output logic hostReady,
	output logic hostRspValid,
	output logic [dataWidth-1:0] hostRData,
	output logic hostFault
);

	logic stall;
	logic issValid;
	logic issIsLoad;
	logic [regIdWidth-1:0] issRd;
	logic [dataWidth-1:0] issValue;

	memBus #(.dataWidth(dataWidth)) coreBus ();
	memBus #(.dataWidth(dataWidth)) hostBus ();
	memBus #(.dataWidth(dataWidth)) ramBus ();

	exIssueStage #(.dataWidth(dataWidth)) i_exIssueStage (
		.clock, .rstN, .opValid, .opWord, .regValRs, .regValRt, .flush, .stall,
		.opReady, .issValid, .issIsLoad, .issRd, .issValue,
		.mem(coreBus.requester)
	);

	exCompleteStage #(.dataWidth(dataWidth)) i_exCompleteStage (
		.clock, .rstN, .issValid, .issIsLoad, .issRd, .issValue,
		.rspValid(coreBus.rspValid),		// Load data back from the arbiter
		.rspData(coreBus.rspData),
		.rspFault(coreBus.rspFault),
		.stall, .wbValid, .wbRegId, .wbValue, .wbFault
	);

	hostPort #(.dataWidth(dataWidth)) i_hostPort (
		.clock, .rstN, .hostValid, .hostWrite, .hostAddr, .hostWData,
		.hostReady, .hostRspValid, .hostRData, .hostFault,
		.mem(hostBus.requester)
	);

	memArbiter i_memArbiter (
		.clock, .rstN,
		.coreSide(coreBus.responder),
		.hostSide(hostBus.responder),
		.ramSide(ramBus.requester)
	);

	scratchRam #(.memDepth(memDepth), .dataWidth(dataWidth)) i_scratchRam (
		.clock, .rstN,
		.mem(ramBus.responder)
	);

endmodule

// File: verification/exCoreTb.sv
module exCoreTb import exPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int memDepth = 256;
	localparam int dataWidth = 32;
	localparam int numOps = 400;
	localparam int cyclesPerOp = 20;

	typedef struct packed {
		logic [regIdWidth-1:0] rd;
		logic [dataWidth-1:0] value;
		logic fault;
	} wbEntry;

	logic clock, rstN, opValid, flush, hostValid, hostWrite;
	uopWord opWord;
	logic [dataWidth-1:0] regValRs, regValRt, hostWData;
	logic [addrWidth-1:0] hostAddr;
	logic opReady, wbValid, wbFault, hostReady, hostRspValid, hostFault;
	logic [regIdWidth-1:0] wbRegId;
	logic [dataWidth-1:0] wbValue, hostRData;

	logic [dataWidth-1:0] model [1024];		// Reference memory
	wbEntry expQ[$];
	logic [dataWidth:0] hostExpQ[$];		// Fault in the top bit
	logic wbGood = 1'b1;
	logic hostGood = 1'b1;
	int errors = 0;
	int countErrors = 0;
	int wbExpected = 0, wbSeen = 0, hostReqs = 0, hostRsps = 0;

	exCore #(.memDepth(memDepth), .dataWidth(dataWidth)) i_exCore (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Whole run may take every op at its worst latency
	initial begin
		#(numOps * cyclesPerOp * 100);
		$display("Watchdog expired, the DUT stopped responding");
		$display("TEST FAIL");
		$finish;
	end

	function automatic logic [dataWidth-1:0] expectedAlu(aluFn fn, logic [dataWidth-1:0] a,
			logic [dataWidth-1:0] b);
		case (fn)
			fnAdd: return a + b;
			fnSub: return a - b;
			fnAnd: return a & b;
			fnOr: return a | b;
			fnXor: return a ^ b;
			fnShl: return a << (b % 32);
			default: return '0;
		endcase
	endfunction

	function automatic uopWord makeAluOp(aluFn fn, logic [3:0] rd, logic useImm, logic [3:0] imm);
		uopWord w;
		w.alu.cmd = cmdAlu;
		w.alu.rd = rd;
		w.alu.fn = fn;
		w.alu.useImm = useImm;
		w.alu.imm = imm;
		return w;
	endfunction

	function automatic uopWord makeMemOp(opCmd cmd, logic [3:0] rd, logic [7:0] offset);
		uopWord w;
		w.mem.cmd = cmd;
		w.mem.rd = rd;
		w.mem.offset = offset;
		return w;
	endfunction

	task automatic sendOp(uopWord w, logic [dataWidth-1:0] rs, logic [dataWidth-1:0] rt,
			bit doFlush);
		logic [dataWidth-1:0] b;
		logic [addrWidth-1:0] addr;
		logic bad;
		opValid = 1'b1;
		opWord = w;
		regValRs = rs;
		regValRt = rt;
		do @(negedge clock); while (!opReady);
		@(posedge clock);
		#10;
		opValid = 1'b0;
		b = w.alu.useImm ? {28'd0, w.alu.imm} : rt;
		addr = addrWidth'(rs + {24'd0, w.mem.offset});
		bad = addr >= memDepth;
		if (doFlush) begin
			flush = 1'b1;			// Op sits in issue stage this cycle
			@(posedge clock);
			#10;
			flush = 1'b0;
		end else if (w.alu.cmd == cmdAlu) begin
			expQ.push_back('{w.alu.rd, expectedAlu(w.alu.fn, rs, b), 1'b0});
			wbExpected++;
		end else if (w.mem.cmd == cmdLoad) begin
			expQ.push_back('{w.mem.rd, bad ? '0 : model[addr], bad});
			wbExpected++;
		end else if (w.mem.cmd == cmdStore && !bad)
			model[addr] = rt;
	endtask

	task automatic hostSend(logic write, logic [addrWidth-1:0] addr, logic [dataWidth-1:0] data);
		logic bad;
		hostValid = 1'b1;
		hostWrite = write;
		hostAddr = addr;
		hostWData = data;
		do @(negedge clock); while (!hostReady);
		@(posedge clock);
		#10;
		hostValid = 1'b0;
		bad = addr >= memDepth;
		hostExpQ.push_back({bad, (write || bad) ? '0 : model[addr]});
		if (write && !bad)
			model[addr] = data;
		hostReqs++;
	endtask

	task automatic waitIdle();
		while (expQ.size() != 0 || hostExpQ.size() != 0)
			@(posedge clock);
		repeat (4) @(posedge clock);		// Let held stores land
		#10;
	endtask

	// Compare at mid cycle, the assertions below pick up the verdict
	always @(negedge clock) begin
		wbEntry e;
		logic [dataWidth:0] h;
		wbGood = 1'b1;
		hostGood = 1'b1;
		if (wbValid) begin
			wbSeen++;
			if (expQ.size() == 0)
				wbGood = 1'b0;
			else begin
				e = expQ.pop_front();
				wbGood = e.rd === wbRegId && e.value === wbValue && e.fault === wbFault;
			end
		end
		if (hostRspValid) begin
			hostRsps++;
			if (hostExpQ.size() == 0)
				hostGood = 1'b0;
			else begin
				h = hostExpQ.pop_front();
				hostGood = h === {hostFault, hostRData};
			end
		end
	end

	wbMatch: assert property (@(posedge clock) disable iff (!rstN) wbValid |-> wbGood)
		else begin
			errors += 1;
			$display("FAILED %0t: writeback r%0d value %h fault %b differs from model",
				$time, wbRegId, wbValue, wbFault);
		end

	hostMatch: assert property (@(posedge clock) disable iff (!rstN) hostRspValid |-> hostGood)
		else begin
			errors += 1;
			$display("FAILED %0t: host response %h fault %b differs from model",
				$time, hostRData, hostFault);
		end

	// Last reset cycle keeps handshakes closed and outputs idle
	resetQuiet: assert property (@(posedge clock) $rose(rstN) |->
		!opReady && !hostReady && !wbValid && !hostRspValid)
		else begin
			errors += 1;
			$display("FAILED %0t: ready or valid outputs high during reset", $time);
		end

	initial begin
		void'($urandom(32'h55a8_a542));
		{rstN, opValid, flush, hostValid, hostWrite} = '0;
		{opWord, regValRs, regValRt, hostAddr, hostWData} = '0;
		repeat (4) @(posedge clock);
		#10 rstN = 1'b1;
		for (int a = 0; a < memDepth; a++)
			hostSend(1'b1, addrWidth'(a), 32'(a) * 32'h9e37_79b1 ^ 32'h5a5a_0000);
		for (int f = 0; f < 6; f++) begin
			sendOp(makeAluOp(aluFn'(f), 4'(f), 1'b0, 4'd0), $urandom, $urandom, 1'b0);
			sendOp(makeAluOp(aluFn'(f), 4'(f + 6), 1'b1, 4'($urandom)), $urandom, $urandom, 1'b0);
		end
		sendOp(makeMemOp(cmdNop, 4'd1, 8'd0), 0, 0, 1'b0);
		sendOp(makeMemOp(cmdStore, 4'd0, 8'd5), 32'd40, 32'hcafe_f00d, 1'b0);
		sendOp(makeMemOp(cmdLoad, 4'd2, 8'd5), 32'd40, 0, 1'b0);
		sendOp(makeMemOp(cmdStore, 4'd0, 8'd4), 32'd300, 32'hdead_beef, 1'b0);
		sendOp(makeMemOp(cmdLoad, 4'd3, 8'd4), 32'd300, 0, 1'b0);
		sendOp(makeMemOp(cmdLoad, 4'd4, 8'd48), 32'd0, 0, 1'b0);
		sendOp(makeMemOp(cmdStore, 4'd0, 8'd30), 32'd0, 32'h1111_2222, 1'b1);
		sendOp(makeAluOp(fnAdd, 4'd5, 1'b1, 4'd3), 32'd9, 0, 1'b1);
		sendOp(makeMemOp(cmdLoad, 4'd6, 8'd30), 32'd0, 0, 1'b0);
		waitIdle();
		hostSend(1'b1, 10'd10, 32'h0bad_cafe);
		waitIdle();
		sendOp(makeMemOp(cmdLoad, 4'd7, 8'd10), 32'd0, 0, 1'b0);
		sendOp(makeMemOp(cmdStore, 4'd0, 8'd20), 32'd0, 32'h7777_8888, 1'b0);
		waitIdle();
		hostSend(1'b0, 10'd20, 0);
		hostSend(1'b0, 10'd700, 0);
		waitIdle();
		// Core stays below 128, host above 192, so both orders agree
		fork
			for (int i = 0; i < 150; i++)
				case ($urandom_range(0, 3))
					0: sendOp(makeAluOp(aluFn'($urandom_range(0, 5)), 4'($urandom),
						1'($urandom), 4'($urandom)), $urandom, $urandom, $urandom_range(0, 9) == 0);
					1: sendOp(makeMemOp(cmdStore, 4'd0, 8'($urandom_range(0, 63))),
						$urandom_range(0, 63), $urandom, $urandom_range(0, 9) == 0);
					2: sendOp(makeMemOp(cmdLoad, 4'($urandom), 8'($urandom_range(0, 63))),
						$urandom_range(0, 63), 0, $urandom_range(0, 9) == 0);
					default: sendOp(makeMemOp($urandom_range(0, 1) ? cmdLoad : cmdStore,
						4'($urandom), 8'($urandom)), 32'd400, $urandom, 1'b0);
				endcase
			for (int i = 0; i < 60; i++)
				hostSend(1'($urandom), $urandom_range(0, 7) == 0 ? 10'd600 :
					10'($urandom_range(192, 255)), $urandom);
		join
		waitIdle();
		countOk: assert (wbSeen == wbExpected && hostRsps == hostReqs) else begin
			countErrors += 1;
			$display("Lost or duplicated responses: %0d of %0d writebacks, %0d of %0d host",
				wbSeen, wbExpected, hostRsps, hostReqs);
		end
		$display("Errors: %0d value, %0d count", errors, countErrors);
		if (errors == 0 && countErrors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: exCore.f
rtl/exPkg.sv
rtl/memBus.sv
rtl/exIssueStage.sv
rtl/exCompleteStage.sv
rtl/hostPort.sv
rtl/memArbiter.sv
rtl/scratchRam.sv
rtl/exCore.sv
verification/exCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module exCoreTb \
	-f exCore.f --Mdir obj_dir -o simv
./obj_dir/simv | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
	exit 0
else
	exit 1
fi
